/* hdl/dkong_pal_defs.svh */
`ifndef DKONG_PAL_DEFS_SVH
`define DKONG_PAL_DEFS_SVH

`default_nettype none

// ====================
// Pixel clock
// ====================

// System clocks per pixel
`define DK_PIX_DIV 4

// ====================
// Raster geometry
// ====================

// Horizontal in pixels
`define DK_H_TOTAL 384
`define DK_H_VISIBLE 256
`define DK_HSYNC_START 296
`define DK_HSYNC_LEN 32

// Vertical in lines
`define DK_V_TOTAL 264
`define DK_V_VISIBLE 224
`define DK_VSYNC_START 240
`define DK_VSYNC_LEN 8

// ====================
// Palette address layout
// ====================

// Host address bit that picks the colour RAM
`define DK_PAL_BANK_BIT 8

`default_nettype wire

`endif

/* hdl/dkong_pal_pkg.sv */
`default_nettype none

package dkong_pal_pkg;

	// ====================
	// Pixel path
	// ====================

	// Tile or sprite code
	// Bits 1:0 are the colour in a group, 00 is transparent
	typedef logic [5:0] pix_code_t;

	// Palette bank bits from the video board
	typedef logic [1:0] pal_bank_t;

	// Colour RAM address, bank on top of the pixel code
	typedef logic [7:0] pal_addr_t;

	// One colour RAM byte
	typedef logic [7:0] pal_byte_t;

	// One 4-bit colour gun
	typedef logic [3:0] gun_t;

	// ====================
	// Host port
	// ====================

	// Bit 8 high selects RAM f, low selects RAM e
	typedef logic [8:0] host_addr_t;

	// Loader handshake states
	typedef enum logic [1:0]
	{
		LOAD_IDLE,
		LOAD_WRITE,
		LOAD_ACK
	} load_state_t;

endpackage

`default_nettype wire

/* hdl/pixel_timing.sv */
`timescale 1ns/1ps
`include "dkong_pal_defs.svh"
`default_nettype none

module pixel_timing
(
	input  wire  CLK_24M,
	input  wire  W_1EF_RST,
	output logic pix_en,
	output logic cmp_blank_n,
	output logic hsync,
	output logic vsync
);

	// Counter widths from the raster totals
	localparam int DIV_W = $clog2(`DK_PIX_DIV);
	localparam int H_W = $clog2(`DK_H_TOTAL);
	localparam int V_W = $clog2(`DK_V_TOTAL);

	// Terminal counts
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`DK_PIX_DIV - 1);
	localparam logic [H_W-1:0] H_LAST = H_W'(`DK_H_TOTAL - 1);
	localparam logic [V_W-1:0] V_LAST = V_W'(`DK_V_TOTAL - 1);

	logic [DIV_W-1:0] div_cnt;
	logic [H_W-1:0] h_cnt;
	logic [V_W-1:0] v_cnt;
	logic [H_W-1:0] h_next;
	logic [V_W-1:0] v_next;

	// ====================
	// Pixel enable
	// ====================

	// Pulse is registered so it rises on the fourth edge after reset
	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
		begin
			div_cnt <= '0;
			pix_en <= 1'b0;
		end
		else
		begin
			div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
			pix_en <= (div_cnt == DIV_LAST);
		end
	end

	// ====================
	// Raster counters
	// ====================

	// Next position, vertical steps when the line wraps
	always_comb
	begin
		h_next = (h_cnt == H_LAST) ? '0 : h_cnt + 1'b1;
		v_next = v_cnt;
		if (h_cnt == H_LAST)
			v_next = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
	end

	// Blank and sync decoded from the next position
	// so they change on the same edge as the counters
	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
			cmp_blank_n <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else if (pix_en)
		begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			cmp_blank_n <= (h_next < H_W'(`DK_H_VISIBLE)) && (v_next < V_W'(`DK_V_VISIBLE));
			hsync <= (h_next >= H_W'(`DK_HSYNC_START))
				&& (h_next < H_W'(`DK_HSYNC_START + `DK_HSYNC_LEN));
			vsync <= (v_next >= V_W'(`DK_VSYNC_START))
				&& (v_next < V_W'(`DK_VSYNC_START + `DK_VSYNC_LEN));
		end
	end

endmodule

`default_nettype wire

/* hdl/palette_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module palette_ram
	import dkong_pal_pkg::*;
(
	input  wire       CLK_24M,
	input  pal_addr_t rd_addr,
	output pal_byte_t rd_data,
	input  wire       wr_en,
	input  pal_addr_t wr_addr,
	input  pal_byte_t wr_data
);

	// 256 colour entries
	localparam int DEPTH = 2 ** $bits(pal_addr_t);

	pal_byte_t mem [DEPTH];

	// Start from black
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
	end

	// ====================
	// Host write side
	// ====================

	always_ff @(posedge CLK_24M)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// ====================
	// Pixel read side
	// ====================

	// Registered read
	// Same-address write returns the old byte
	always_ff @(posedge CLK_24M)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* hdl/palette_loader.sv */
`timescale 1ns/1ps
`include "dkong_pal_defs.svh"
`default_nettype none

module palette_loader
	import dkong_pal_pkg::*;
(
	input  wire        CLK_24M,
	input  wire        W_1EF_RST,
	input  wire        host_req,
	output logic       host_ack,
	input  host_addr_t host_addr,
	input  pal_byte_t  host_data,
	output logic       wr_en_f,
	output logic       wr_en_e,
	output pal_addr_t  wr_addr,
	output pal_byte_t  wr_data
);

	load_state_t state;

	// RAM select bit of the host address
	logic sel_f;

	assign sel_f = host_addr[`DK_PAL_BANK_BIT];

	// ====================
	// Handshake FSM
	// ====================

	// IDLE waits for req
	// WRITE holds one enable for a single cycle
	// ACK holds ack until req drops
	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
		begin
			state <= LOAD_IDLE;
			host_ack <= 1'b0;
			wr_en_f <= 1'b0;
			wr_en_e <= 1'b0;
		end
		else
		begin
			case (state)
				LOAD_IDLE:
				begin
					if (host_req)
					begin
						state <= LOAD_WRITE;
						// Exactly one RAM gets the write
						wr_en_f <= sel_f;
						wr_en_e <= !sel_f;
					end
				end
				LOAD_WRITE:
				begin
					// Write lands on this edge, ack follows
					state <= LOAD_ACK;
					wr_en_f <= 1'b0;
					wr_en_e <= 1'b0;
					host_ack <= 1'b1;
				end
				LOAD_ACK:
				begin
					// Slow host just parks us here
					if (!host_req)
					begin
						state <= LOAD_IDLE;
						host_ack <= 1'b0;
					end
				end
				default:
				begin
					state <= LOAD_IDLE;
					host_ack <= 1'b0;
					wr_en_f <= 1'b0;
					wr_en_e <= 1'b0;
				end
			endcase
		end
	end

	// ====================
	// Write payload
	// ====================

	// Captured as the request is accepted
	// host holds address and data while req is high
	always_ff @(posedge CLK_24M)
	begin
		if (state == LOAD_IDLE && host_req)
		begin
			wr_addr <= pal_addr_t'(host_addr[`DK_PAL_BANK_BIT-1:0]);
			wr_data <= host_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/dkong_col_pal.sv */
`timescale 1ns/1ps
`default_nettype none

module dkong_col_pal
	import dkong_pal_pkg::*;
(
	input  wire       CLK_24M,
	input  wire       W_1EF_RST,
	input  wire       pix_en,
	// Board wiring straps
	input  wire       direct_mode,
	input  wire       pal_polarity,
	// Pixel inputs
	input  pal_bank_t pal_bank,
	input  pix_code_t vram_code,
	input  pix_code_t obj_code,
	input  wire       cmp_blank_n,
	// Colour RAM write side from the loader
	input  wire       wr_en_f,
	input  wire       wr_en_e,
	input  pal_addr_t wr_addr,
	input  pal_byte_t wr_data,
	// Colour outputs
	output gun_t      red,
	output gun_t      green,
	output gun_t      blue
);

	pix_code_t sel_code;
	pal_addr_t pix_addr;
	pal_byte_t f_byte;
	pal_byte_t e_byte;

	// Packed wiring words before inversion
	gun_t pk_red;
	gun_t pk_green;
	gun_t pk_blue;
	gun_t pol_mask;

	// ====================
	// Priority select
	// ====================

	// Sprite wins unless its colour bits are transparent
	assign sel_code = (obj_code[1:0] != 2'b00) ? obj_code : vram_code;

	// ====================
	// Pixel latch
	// ====================

	// Sampled once per pixel
	// Blanked pixels point at entry 0
	always_ff @(posedge CLK_24M or negedge W_1EF_RST)
	begin
		if (!W_1EF_RST)
			pix_addr <= '0;
		else if (pix_en)
		begin
			if (cmp_blank_n)
				pix_addr <= {pal_bank, sel_code};
			else
				pix_addr <= '0;
		end
	end

	// ====================
	// Colour RAMs
	// ====================

	// First RAM holds red and green in direct wiring
	palette_ram pal_f
	(
		.CLK_24M (CLK_24M),
		.rd_addr (pix_addr),
		.rd_data (f_byte),
		.wr_en   (wr_en_f),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	// Second RAM holds blue in direct wiring
	palette_ram pal_e
	(
		.CLK_24M (CLK_24M),
		.rd_addr (pix_addr),
		.rd_data (e_byte),
		.wr_en   (wr_en_e),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	// ====================
	// RGB decode
	// ====================

	// Packed board bit shuffle
	assign pk_red = {f_byte[3], f_byte[2], f_byte[1], f_byte[3]};
	assign pk_green = {f_byte[0], e_byte[3], e_byte[2], f_byte[0]};
	assign pk_blue = {e_byte[1], e_byte[0], e_byte[1], e_byte[0]};

	// Polarity pin flips all four bits of every gun
	assign pol_mask = {4{pal_polarity}};

	// Pure combinational from RAM outputs and straps
	always_comb
	begin
		if (direct_mode)
		begin
			// Plain nibble unpack
			red = f_byte[7:4];
			green = f_byte[3:0];
			blue = e_byte[3:0];
		end
		else
		begin
			// Inverted then polarity XOR
			red = pol_mask ^ ~pk_red;
			green = pol_mask ^ ~pk_green;
			blue = pol_mask ^ ~pk_blue;
		end
	end

endmodule

`default_nettype wire

/* hdl/dkong_video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dkong_video_top
	import dkong_pal_pkg::*;
(
	input  wire        CLK_24M,
	input  wire        W_1EF_RST,
	// Board straps
	input  wire        direct_mode,
	input  wire        pal_polarity,
	// Pixel inputs
	input  pal_bank_t  pal_bank,
	input  pix_code_t  vram_code,
	input  pix_code_t  obj_code,
	// Host write port
	input  wire        host_req,
	output logic       host_ack,
	input  host_addr_t host_addr,
	input  pal_byte_t  host_data,
	// Timing
	output logic       pix_en,
	output logic       cmp_blank_n,
	output logic       hsync,
	output logic       vsync,
	// Colour
	output gun_t       red,
	output gun_t       green,
	output gun_t       blue
);

	// Loader to colour RAM write bus
	logic      wr_en_f;
	logic      wr_en_e;
	pal_addr_t wr_addr;
	pal_byte_t wr_data;

	// ====================
	// Raster timing
	// ====================

	pixel_timing u_timing
	(
		.CLK_24M     (CLK_24M),
		.W_1EF_RST   (W_1EF_RST),
		.pix_en      (pix_en),
		.cmp_blank_n (cmp_blank_n),
		.hsync       (hsync),
		.vsync       (vsync)
	);

	// ====================
	// Host loader
	// ====================

	palette_loader u_loader
	(
		.CLK_24M   (CLK_24M),
		.W_1EF_RST (W_1EF_RST),
		.host_req  (host_req),
		.host_ack  (host_ack),
		.host_addr (host_addr),
		.host_data (host_data),
		.wr_en_f   (wr_en_f),
		.wr_en_e   (wr_en_e),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	// ====================
	// Colour back end
	// ====================

	dkong_col_pal u_col_pal
	(
		.CLK_24M      (CLK_24M),
		.W_1EF_RST    (W_1EF_RST),
		.pix_en       (pix_en),
		.direct_mode  (direct_mode),
		.pal_polarity (pal_polarity),
		.pal_bank     (pal_bank),
		.vram_code    (vram_code),
		.obj_code     (obj_code),
		.cmp_blank_n  (cmp_blank_n),
		.wr_en_f      (wr_en_f),
		.wr_en_e      (wr_en_e),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.red          (red),
		.green        (green),
		.blue         (blue)
	);

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
	output logic CLK_24M,
	output logic W_1EF_RST
);

	// 10 ns period
	localparam int HALF_NS = 5;
	localparam int RESET_CYCLES = 4;

	initial
	begin
		CLK_24M = 1'b0;
		forever #(HALF_NS) CLK_24M = ~CLK_24M;
	end

	// Reset held low for four rising edges, released just after the last
	initial
	begin
		W_1EF_RST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_24M);
		#1;
		W_1EF_RST = 1'b1;
	end

endmodule

`default_nettype wire

/* bench/dkong_video_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dkong_video_sva
(
	input wire CLK_24M,
	input wire W_1EF_RST,
	input wire host_req,
	input wire host_ack,
	input wire pix_en,
	input wire wr_en_f,
	input wire wr_en_e
);

	// Number of assertion failures so far
	int fail_count = 0;

	// ====================
	// Host handshake
	// ====================

	// Ack only ever answers a live request
	ack_needs_req: assert property (@(posedge CLK_24M) disable iff (!W_1EF_RST)
		$rose(host_ack) |-> host_req)
	else
	begin
		fail_count++;
		$error("host_ack rose while host_req was low");
	end

	// Every accepted request writes exactly one colour RAM
	one_ram_write: assert property (@(posedge CLK_24M) disable iff (!W_1EF_RST)
		$rose(host_req) |=> $onehot({wr_en_f, wr_en_e}))
	else
	begin
		fail_count++;
		$error("request did not write exactly one colour RAM");
	end

	// ====================
	// Pixel timing
	// ====================

	// Single cycle pulse, one in every four clocks
	pix_en_period: assert property (@(posedge CLK_24M) disable iff (!W_1EF_RST)
		pix_en |=> !pix_en ##1 !pix_en ##1 !pix_en ##1 pix_en)
	else
	begin
		fail_count++;
		$error("pix_en is not a single cycle pulse every four clocks");
	end

endmodule

`default_nettype wire

/* bench/tb_dkong_video.sv */
`timescale 1ns/1ps
`include "dkong_pal_defs.svh"
`default_nettype none

module tb_dkong_video
	import dkong_pal_pkg::*;
();

	localparam int LINE_CYCLES = `DK_PIX_DIV * `DK_H_TOTAL;
	localparam int FRAME_CYCLES = LINE_CYCLES * `DK_V_TOTAL;
	localparam int VIS_PIXELS = `DK_H_VISIBLE * `DK_V_VISIBLE;
	// Full fill plus two rewrite bytes
	localparam int N_WRITES = 514;
	localparam int ACK_LIMIT = 8;
	// Budget in ns at 10 ns per cycle
	localparam int WATCH_NS = 10 * (N_WRITES * 20 + 3 * FRAME_CYCLES);

	wire CLK_24M;
	wire W_1EF_RST;

	// DUT inputs
	logic direct_mode;
	logic pal_polarity;
	pal_bank_t pal_bank;
	pix_code_t vram_code;
	pix_code_t obj_code;
	logic host_req;
	host_addr_t host_addr;
	pal_byte_t host_data;

	// DUT outputs
	logic host_ack;
	logic pix_en;
	logic cmp_blank_n;
	logic hsync;
	logic vsync;
	gun_t red;
	gun_t green;
	gun_t blue;

	// Palette model, index is the host address
	pal_byte_t model [512];

	// Values applied at the next drive point
	logic mode_q;
	logic pol_q;
	logic req_q;
	host_addr_t addr_q;
	pal_byte_t data_q;

	// Pixel in flight through latch and RAM
	logic pend_valid;
	int pend_age;
	pal_addr_t pend_addr;

	// Rewritten entry
	logic hot_on;
	pal_addr_t hot_addr;
	int hot_hits;

	// Raster model, steps on each pix_en
	int edge_count;
	int h_pos;
	int v_pos;
	logic raster_on;
	logic blank_exp;

	// Frame bookkeeping
	logic vsync_prev;
	logic ack_prev;
	logic count_on;
	int vis_count;
	int frames_seen;

	tb_clock_gen clk_gen0
	(
		.CLK_24M   (CLK_24M),
		.W_1EF_RST (W_1EF_RST)
	);

	dkong_video_top dut0 (.*);

	bind dkong_video_top dkong_video_sva sva0
	(
		.CLK_24M   (CLK_24M),
		.W_1EF_RST (W_1EF_RST),
		.host_req  (host_req),
		.host_ack  (host_ack),
		.pix_en    (pix_en),
		.wr_en_f   (wr_en_f),
		.wr_en_e   (wr_en_e)
	);

	// ====================
	// Checks
	// ====================

	task automatic report_failure(input string what);
		$display("%s at %0t", what, $time);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_gun(input string name, input gun_t got, input gun_t exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_byte_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_ack(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// Expected guns for one RAM address, from the board wiring rules
	function automatic logic [11:0] expect_rgb(input pal_addr_t a, input logic dm,
		input logic pol);
		pal_byte_t f;
		pal_byte_t e;
		gun_t inv;
		f = model[{1'b1, a}];
		e = model[{1'b0, a}];
		inv = {4{~pol}};
		if (dm)
			return {f[7:4], f[3:0], e[3:0]};
		return {inv ^ {f[3], f[2], f[1], f[3]},
			inv ^ {f[0], e[3], e[2], f[0]},
			inv ^ {e[1], e[0], e[1], e[0]}};
	endfunction

	// ====================
	// Per cycle drive and sample
	// ====================

	// Random codes, often forced onto the rewritten entry
	task automatic drive_pixel();
		pal_bank = pal_bank_t'($urandom);
		vram_code = pix_code_t'($urandom);
		obj_code = pix_code_t'($urandom);
		if (hot_on && ($urandom % 4 != 0))
		begin
			pal_bank = hot_addr[7:6];
			vram_code = hot_addr[5:0];
			// Transparent sprite lets the tile through
			obj_code[1:0] = 2'b00;
		end
	endtask

	// Runs at the falling edge, all DUT outputs settled
	task automatic sample_outputs();
		logic [11:0] exp_rgb;
		pix_code_t sel;
		if (dut0.sva0.fail_count != 0)
			report_failure("a concurrent assertion failed");
		// Ack must not drop under a live request
		if (host_req && ack_prev && !host_ack)
			check_ack("host_ack", host_ack, 1'b1);
		ack_prev = host_ack;
		// Raster outputs against the counter model
		edge_count++;
		check_flag("pix_en", pix_en, (edge_count % `DK_PIX_DIV) == 0);
		blank_exp = raster_on && (h_pos < `DK_H_VISIBLE) && (v_pos < `DK_V_VISIBLE);
		check_flag("cmp_blank_n", cmp_blank_n, blank_exp);
		check_flag("hsync", hsync, raster_on && (h_pos >= `DK_HSYNC_START)
			&& (h_pos < `DK_HSYNC_START + `DK_HSYNC_LEN));
		check_flag("vsync", vsync, raster_on && (v_pos >= `DK_VSYNC_START)
			&& (v_pos < `DK_VSYNC_START + `DK_VSYNC_LEN));
		// Colour valid one edge after the latch edge
		if (pend_valid)
		begin
			pend_age++;
			if (pend_age == 2)
			begin
				exp_rgb = expect_rgb(pend_addr, direct_mode, pal_polarity);
				check_gun("red", red, exp_rgb[11:8]);
				check_gun("green", green, exp_rgb[7:4]);
				check_gun("blue", blue, exp_rgb[3:0]);
				if (hot_on && pend_addr == hot_addr)
					hot_hits++;
				pend_valid = 1'b0;
			end
		end
		// Next edge latches this pixel
		if (pix_en)
		begin
			// Opaque sprite pixel beats the tile
			if (obj_code[1] || obj_code[0])
				sel = obj_code;
			else
				sel = vram_code;
			pend_addr = blank_exp ? {pal_bank, sel} : '0;
			pend_age = 0;
			pend_valid = 1'b1;
			if (cmp_blank_n)
				vis_count++;
			// Same edge moves the raster on
			h_pos = (h_pos + 1) % `DK_H_TOTAL;
			if (h_pos == 0)
				v_pos = (v_pos + 1) % `DK_V_TOTAL;
			raster_on = 1'b1;
		end
		// Frame boundary on vsync rise
		if (vsync && !vsync_prev)
		begin
			if (count_on)
				check_byte_count("visible pix_en per frame", vis_count, VIS_PIXELS);
			vis_count = 0;
			count_on = 1'b1;
			frames_seen++;
		end
		vsync_prev = vsync;
	endtask

	task automatic tick();
		@(posedge CLK_24M);
		#1;
		drive_pixel();
		direct_mode = mode_q;
		pal_polarity = pol_q;
		host_req = req_q;
		host_addr = addr_q;
		host_data = data_q;
		@(negedge CLK_24M);
		sample_outputs();
	endtask

	// Four-phase write, model follows once ack is seen
	task automatic host_write(input host_addr_t addr, input pal_byte_t data);
		int n;
		req_q = 1'b1;
		addr_q = addr;
		data_q = data;
		n = 0;
		do
		begin
			tick();
			n++;
		end
		while (!host_ack && n < ACK_LIMIT);
		check_ack("host_ack", host_ack, 1'b1);
		model[addr] = data;
		// One more cycle with req up, ack has to hold
		tick();
		req_q = 1'b0;
		n = 0;
		do
		begin
			tick();
			n++;
		end
		while (host_ack && n < ACK_LIMIT);
		check_ack("host_ack", host_ack, 1'b0);
	endtask

	task automatic run_to_frame_end();
		int start;
		start = frames_seen;
		while (frames_seen == start)
			tick();
	endtask

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		void'($urandom(94));
		direct_mode = 1'b1;
		pal_polarity = 1'b0;
		pal_bank = '0;
		vram_code = '0;
		obj_code = '0;
		host_req = 1'b0;
		host_addr = '0;
		host_data = '0;
		mode_q = 1'b1;
		pol_q = 1'b0;
		req_q = 1'b0;
		addr_q = '0;
		data_q = '0;
		pend_valid = 1'b0;
		pend_age = 0;
		pend_addr = '0;
		hot_on = 1'b0;
		hot_addr = '0;
		hot_hits = 0;
		edge_count = 0;
		h_pos = 0;
		v_pos = 0;
		raster_on = 1'b0;
		blank_exp = 1'b0;
		vsync_prev = 1'b0;
		ack_prev = 1'b0;
		count_on = 1'b0;
		vis_count = 0;
		frames_seen = 0;
		// RAMs start black
		for (int i = 0; i < 512; i++)
			model[i] = '0;
		@(posedge W_1EF_RST);
		// Fill both RAMs, direct wiring checked meanwhile
		for (int i = 0; i < 512; i++)
			host_write(host_addr_t'(i), pal_byte_t'($urandom));
		run_to_frame_end();
		// Packed wiring, new polarity each frame
		for (int f = 0; f < 2; f++)
		begin
			mode_q = 1'b0;
			pol_q = 1'($urandom % 2);
			if (f == 0)
			begin
				// From vsync to line 100
				repeat ((`DK_V_TOTAL - `DK_VSYNC_START + 100) * LINE_CYCLES)
					tick();
				hot_addr = pal_addr_t'($urandom);
				host_write({1'b1, hot_addr},
					model[{1'b1, hot_addr}] ^ (pal_byte_t'($urandom) | 8'h01));
				host_write({1'b0, hot_addr},
					model[{1'b0, hot_addr}] ^ (pal_byte_t'($urandom) | 8'h01));
				hot_on = 1'b1;
			end
			run_to_frame_end();
		end
		if (hot_hits == 0)
			report_failure("no pixel selected the rewritten palette entry");
		if (dut0.sva0.fail_count == 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
		begin
			$display("%0d assertion failures", dut0.sva0.fail_count);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	// Watchdog
	initial
	begin
		#(WATCH_NS);
		$display("watchdog expired before the tests finished");
		$display("** FAIL **");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/dkong_pal_pkg.sv
hdl/pixel_timing.sv
hdl/palette_ram.sv
hdl/palette_loader.sv
hdl/dkong_col_pal.sv
hdl/dkong_video_top.sv
bench/tb_clock_gen.sv
bench/dkong_video_sva.sv
bench/tb_dkong_video.sv
